/* sources.f */
+incdir+hdl
hdl/gat_debug_pkg.sv
hdl/stage_monitor.sv
hdl/sppe_capture.sv
hdl/feat_write_watch.sv
hdl/debug_axil_regs.sv
hdl/gat_debugger.sv
sim/debug_clk_gen.sv
sim/tb_gat_debugger.sv

/* sim/tb_gat_debugger.sv */
`timescale 1ns/10ps
`include "gat_debug_config.svh"

module tb_gat_debugger;

  import gat_debug_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;

  logic        clk;
  logic        rst_n;
  gat_probe_t  probe;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  logic [31:0] lfsr_state;
  int          mismatch_count;
  int          other_count;

  // reference state from the register map rules.
  logic [3:0]  m_vld_seen;
  logic [3:0]  m_rdy_seen;
  logic [31:0] m_count [4];
  logic [11:0] m_cap_a;
  logic [11:0] m_cap_b;
  logic        m_hit_a;
  logic        m_hit_b;
  logic        m_feat_hit;
  logic [15:0] m_feat_addr;
  logic [31:0] m_feat_din;
  logic [13:0] m_trig_a;
  logic [13:0] m_trig_b;
  logic [3:0]  m_lane;
  logic [15:0] m_limit;

  debug_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_debugger u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .probe_i          (probe),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  // galois form of x^32 + x^22 + x^2 + x + 1 stepped once per bit.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return bits;
  endfunction

  function automatic void model_clear();
    m_vld_seen  = '0;
    m_rdy_seen  = '0;
    for (int s = 0; s < 4; s++) begin
      m_count[s] = '0;
    end
    m_cap_a     = '0;
    m_cap_b     = '0;
    m_hit_a     = 1'b0;
    m_hit_b     = 1'b0;
    m_feat_hit  = 1'b0;
    m_feat_addr = '0;
    m_feat_din  = '0;
  endfunction

  // one probe cycle as the observer should see it.
  function automatic void model_update(input gat_probe_t p);
    for (int s = 0; s < 4; s++) begin
      if (p.hs[s].vld) begin
        m_vld_seen[s] = 1'b1;
      end
      if (p.hs[s].rdy) begin
        m_rdy_seen[s] = 1'b1;
      end
      if (p.hs[s].vld && p.hs[s].rdy) begin
        m_count[s] = m_count[s] + 32'd1;
      end
    end
    if (p.hs[0].rdy && p.wh_addr == m_trig_a) begin
      m_cap_a = p.sppe[m_lane];
      m_hit_a = 1'b1;
    end
    if (p.hs[0].rdy && p.wh_addr == m_trig_b) begin
      m_cap_b = p.sppe[m_lane];
      m_hit_b = 1'b1;
    end
    if (p.feat_ena && p.feat_addr >= m_limit && !m_feat_hit) begin
      m_feat_hit  = 1'b1;
      m_feat_addr = p.feat_addr;
      m_feat_din  = p.feat_din;
    end
  endfunction

  function automatic void model_write(input logic [7:0] addr, input logic [31:0] data);
    case (addr)
      `GAT_DBG_REG_CTRL: begin
        if (data[0]) begin
          model_clear();
        end
      end
      `GAT_DBG_REG_TRIG_A:   m_trig_a = data[13:0];
      `GAT_DBG_REG_TRIG_B:   m_trig_b = data[13:0];
      `GAT_DBG_REG_LANE:     m_lane = data[3:0];
      `GAT_DBG_REG_FEAT_LIM: m_limit = data[15:0];
      default: ;
    endcase
  endfunction

  function automatic logic [31:0] expected_reg(input logic [7:0] addr);
    logic [31:0] v;
    v = '0;
    case (addr)
      `GAT_DBG_REG_ID:  v = `GAT_DBG_ID;
      `GAT_DBG_REG_CFG: v = 32'd12;
      `GAT_DBG_REG_FLAGS: begin
        // spmm in bits 7:6, aggr in bits 1:0.
        for (int s = 0; s < 4; s++) begin
          v[7-2*s] = m_vld_seen[s];
          v[6-2*s] = m_rdy_seen[s];
        end
      end
      `GAT_DBG_REG_CNT0:      v = m_count[0];
      `GAT_DBG_REG_CNT1:      v = m_count[1];
      `GAT_DBG_REG_CNT2:      v = m_count[2];
      `GAT_DBG_REG_CNT3:      v = m_count[3];
      `GAT_DBG_REG_TRIG_A:    v[13:0] = m_trig_a;
      `GAT_DBG_REG_TRIG_B:    v[13:0] = m_trig_b;
      `GAT_DBG_REG_LANE:      v[3:0] = m_lane;
      `GAT_DBG_REG_CAP_A:     v = {m_hit_a, 19'd0, m_cap_a};
      `GAT_DBG_REG_CAP_B:     v = {m_hit_b, 19'd0, m_cap_b};
      `GAT_DBG_REG_FEAT_LIM:  v[15:0] = m_limit;
      `GAT_DBG_REG_FEAT_STAT: v = {m_feat_hit, 15'd0, m_feat_addr};
      `GAT_DBG_REG_FEAT_DIN:  v = m_feat_din;
      default:                v = '0;
    endcase
    return v;
  endfunction

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [1:0] exp_resp);
    int waited;
    waited  = 0;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    bready  = 1'b1;
    @(posedge clk);
    if (!awready || !wready) begin
      $display("%0t: write to 0x%02h was not accepted with both valids high", $time, addr);
      other_count++;
    end
    do begin
      @(negedge clk);
      waited++;
    end while (!bvalid && waited < TIMEOUT_CYCLES);
    if (bvalid && (awready || wready)) begin
      $display("%0t: write channel was ready again while bvalid was pending", $time);
      other_count++;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!bvalid) begin
      $display("%0t: write to 0x%02h got no response", $time, addr);
      other_count++;
    end else begin
      if (waited != 1) begin
        $display("%0t: write response came after %0d cycles, not 1", $time, waited);
        other_count++;
      end
      if (bresp != exp_resp) begin
        $display("Mismatch at %0t: write 0x%02h bresp %0d, expected %0d",
                 $time, addr, bresp, exp_resp);
        mismatch_count++;
      end
      model_write(addr, data);
    end
    @(negedge clk);
    bready = 1'b0;
  endtask

  // rready stays low for hold cycles once rvalid is up.
  task automatic axil_read(input logic [7:0] addr, input int hold,
                           output logic [31:0] data, output logic [1:0] resp);
    int waited;
    waited  = 0;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = (hold == 0);
    @(posedge clk);
    if (!arready) begin
      $display("%0t: arready was low while the read side was idle", $time);
      other_count++;
    end
    do begin
      @(negedge clk);
      waited++;
    end while (!rvalid && waited < TIMEOUT_CYCLES);
    arvalid = 1'b0;
    data    = rdata;
    resp    = rresp;
    if (!rvalid) begin
      $display("%0t: read of 0x%02h got no response", $time, addr);
      other_count++;
    end else begin
      if (waited != 1) begin
        $display("%0t: read data came after %0d cycles, not 1", $time, waited);
        other_count++;
      end
      for (int i = 0; i < hold; i++) begin
        @(negedge clk);
        if (!rvalid || rdata !== data) begin
          $display("Mismatch at %0t: read of 0x%02h not held while rready low",
                   $time, addr);
          mismatch_count++;
        end
        if (arready) begin
          $display("%0t: arready rose while a read response was pending", $time);
          other_count++;
        end
      end
    end
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic check_reg(input logic [7:0] addr);
    logic [31:0] exp;
    logic [31:0] data;
    logic [1:0]  resp;
    exp = expected_reg(addr);
    axil_read(addr, 0, data, resp);
    if (resp != OKAY) begin
      $display("Mismatch at %0t: read 0x%02h rresp %0d, expected OKAY", $time, addr, resp);
      mismatch_count++;
    end
    if (data !== exp) begin
      $display("Mismatch at %0t: reg 0x%02h read 0x%08h, expected 0x%08h",
               $time, addr, data, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_all();
    for (int a = 0; a < 'h40; a += 4) begin
      check_reg(a[7:0]);
    end
  endtask

  task automatic run_random(input int cycles, input bit hs_on, input bit cap_on,
                            input bit feat_on);
    gat_probe_t  p;
    logic [31:0] r;
    for (int c = 0; c < cycles; c++) begin
      p = '0;
      if (hs_on) begin
        r    = take_bits(8);
        p.hs = r[7:0];
      end
      if (cap_on) begin
        r = take_bits(1);
        p.hs[SPMM].rdy = r[0];
        for (int l = 0; l < 16; l++) begin
          r         = take_bits(12);
          p.sppe[l] = r[11:0];
        end
        // half of the addresses land on a trigger.
        r = take_bits(2);
        case (r[1:0])
          2'd0:    p.wh_addr = m_trig_a;
          2'd1:    p.wh_addr = m_trig_b;
          default: begin
            r         = take_bits(14);
            p.wh_addr = r[13:0];
          end
        endcase
      end
      if (feat_on) begin
        r          = take_bits(1);
        p.feat_ena = r[0];
        p.feat_din = take_bits(32);
        r          = take_bits(2);
        case (r[1:0])
          2'd0: begin
            r           = take_bits(3);
            p.feat_addr = m_limit + r[15:0];
          end
          2'd1: begin
            r           = take_bits(3);
            p.feat_addr = m_limit - 16'd1 - r[15:0];
          end
          default: begin
            r           = take_bits(16);
            p.feat_addr = r[15:0];
          end
        endcase
      end
      @(negedge clk);
      probe = p;
      model_update(p);
    end
    @(negedge clk);
    probe = '0;
  endtask

  initial begin
    int          waited;
    logic [31:0] data;
    logic [1:0]  resp;
    lfsr_state     = 32'h62f8_7abb;
    mismatch_count = 0;
    other_count    = 0;
    probe          = '0;
    awaddr         = '0;
    awvalid        = 1'b0;
    wdata          = '0;
    wstrb          = 4'hf;
    wvalid         = 1'b0;
    bready         = 1'b0;
    araddr         = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    model_clear();
    m_trig_a = 14'd10;
    m_trig_b = 14'd20;
    m_lane   = 4'd2;
    m_limit  = 16'd43328;

    waited = 0;
    while (rst_n !== 1'b1 && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("%0t: reset was never released", $time);
      other_count++;
    end
    if (arready !== 1'b1 || bvalid !== 1'b0 || rvalid !== 1'b0) begin
      $display("%0t: AXI handshake outputs were not idle after reset", $time);
      other_count++;
    end

    check_all();

    run_random(300, 1'b1, 1'b0, 1'b0);
    check_all();

    run_random(150, 1'b0, 1'b1, 1'b0);
    check_all();
    axil_write(`GAT_DBG_REG_TRIG_A, 32'h0000_1a2b, OKAY);
    axil_write(`GAT_DBG_REG_TRIG_B, 32'h0000_0777, OKAY);
    axil_write(`GAT_DBG_REG_LANE, 32'd9, OKAY);
    run_random(150, 1'b0, 1'b1, 1'b0);
    check_all();
    if (!m_hit_a || !m_hit_b) begin
      $display("%0t: capture stimulus never hit both triggers", $time);
      other_count++;
    end

    axil_write(`GAT_DBG_REG_FEAT_LIM, 32'h0000_2000, OKAY);
    run_random(120, 1'b0, 1'b0, 1'b1);
    check_all();
    if (!m_feat_hit) begin
      $display("%0t: feature stimulus never wrote past the limit", $time);
      other_count++;
    end
    run_random(80, 1'b0, 1'b0, 1'b1);
    check_all();

    // read-only offsets take writes quietly, unmapped ones do not.
    axil_write(`GAT_DBG_REG_ID, 32'hffff_ffff, OKAY);
    axil_write(8'h40, 32'h0000_0001, SLVERR);

    axil_write(`GAT_DBG_REG_CTRL, 32'h0000_0001, OKAY);
    check_all();

    axil_read(8'h40, 0, data, resp);
    if (resp != SLVERR || data !== 32'd0) begin
      $display("Mismatch at %0t: unmapped read gave resp %0d data 0x%08h", $time, resp, data);
      mismatch_count++;
    end
    axil_read(`GAT_DBG_REG_TRIG_A, 4, data, resp);
    if (data !== expected_reg(`GAT_DBG_REG_TRIG_A)) begin
      $display("Mismatch at %0t: held read returned 0x%08h", $time, data);
      mismatch_count++;
    end

    $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sim/debug_clk_gen.sv */
`timescale 1ns/10ps

module debug_clk_gen #(
  parameter int HALF_PERIOD_NS = 50,
  parameter int RST_CYCLES     = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

  always #(HALF_PERIOD_NS) clk_o = ~clk_o;

endmodule

/* hdl/gat_debugger.sv */
`timescale 1ns/10ps
`include "gat_debug_config.svh"

module gat_debugger (
  input  logic                              clk,
  input  logic                              rst_n,
  input  gat_debug_pkg::gat_probe_t         probe_i,
  input  logic [`GAT_DBG_AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
  input  logic                              s_axil_awvalid_i,
  output logic                              s_axil_awready_o,
  input  logic [`GAT_DBG_AXIL_DATA_W-1:0]   s_axil_wdata_i,
  input  logic [`GAT_DBG_AXIL_DATA_W/8-1:0] s_axil_wstrb_i,
  input  logic                              s_axil_wvalid_i,
  output logic                              s_axil_wready_o,
  output logic [1:0]                        s_axil_bresp_o,
  output logic                              s_axil_bvalid_o,
  input  logic                              s_axil_bready_i,
  input  logic [`GAT_DBG_AXIL_ADDR_W-1:0]   s_axil_araddr_i,
  input  logic                              s_axil_arvalid_i,
  output logic                              s_axil_arready_o,
  output logic [`GAT_DBG_AXIL_DATA_W-1:0]   s_axil_rdata_o,
  output logic [1:0]                        s_axil_rresp_o,
  output logic                              s_axil_rvalid_o,
  input  logic                              s_axil_rready_i
);

  import gat_debug_pkg::*;

  dbg_ctrl_t                              ctrl;
  stage_status_t [`GAT_DBG_NUM_STAGES-1:0] stage_status;
  cap_status_t                            cap_status;
  feat_status_t                           feat_status;

  for (genvar i = 0; i < `GAT_DBG_NUM_STAGES; i++) begin : g_stage
    stage_monitor u_stage_monitor (
      .clk      (clk),
      .rst_n    (rst_n),
      .probe_i  (probe_i.hs[i]),
      .clear_i  (ctrl.clear),
      .status_o (stage_status[i])
    );
  end

  sppe_capture u_sppe_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .sppe_i     (probe_i.sppe),
    .wh_addr_i  (probe_i.wh_addr),
    .spmm_rdy_i (probe_i.hs[SPMM].rdy),
    .ctrl_i     (ctrl),
    .status_o   (cap_status)
  );

  feat_write_watch u_feat_write_watch (
    .clk      (clk),
    .rst_n    (rst_n),
    .ena_i    (probe_i.feat_ena),
    .addr_i   (probe_i.feat_addr),
    .din_i    (probe_i.feat_din),
    .ctrl_i   (ctrl),
    .status_o (feat_status)
  );

  debug_axil_regs u_debug_axil_regs (
    .clk              (clk),
    .rst_n            (rst_n),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .stage_status_i   (stage_status),
    .cap_status_i     (cap_status),
    .feat_status_i    (feat_status),
    .ctrl_o           (ctrl)
  );

endmodule

/* hdl/debug_axil_regs.sv */
`timescale 1ns/10ps
`include "gat_debug_config.svh"

module debug_axil_regs (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  logic [`GAT_DBG_AXIL_ADDR_W-1:0]                        s_axil_awaddr_i,
  input  logic                                                   s_axil_awvalid_i,
  output logic                                                   s_axil_awready_o,
  input  logic [`GAT_DBG_AXIL_DATA_W-1:0]                        s_axil_wdata_i,
  input  logic [`GAT_DBG_AXIL_DATA_W/8-1:0]                      s_axil_wstrb_i,
  input  logic                                                   s_axil_wvalid_i,
  output logic                                                   s_axil_wready_o,
  output logic [1:0]                                             s_axil_bresp_o,
  output logic                                                   s_axil_bvalid_o,
  input  logic                                                   s_axil_bready_i,
  input  logic [`GAT_DBG_AXIL_ADDR_W-1:0]                        s_axil_araddr_i,
  input  logic                                                   s_axil_arvalid_i,
  output logic                                                   s_axil_arready_o,
  output logic [`GAT_DBG_AXIL_DATA_W-1:0]                        s_axil_rdata_o,
  output logic [1:0]                                             s_axil_rresp_o,
  output logic                                                   s_axil_rvalid_o,
  input  logic                                                   s_axil_rready_i,
  input  gat_debug_pkg::stage_status_t [`GAT_DBG_NUM_STAGES-1:0] stage_status_i,
  input  gat_debug_pkg::cap_status_t                             cap_status_i,
  input  gat_debug_pkg::feat_status_t                            feat_status_i,
  output gat_debug_pkg::dbg_ctrl_t                               ctrl_o
);

  import gat_debug_pkg::*;

  axil_state_e                       w_state;
  axil_state_e                       r_state;
  axil_resp_e                        bresp_q;
  axil_resp_e                        rresp_q;
  axil_resp_e                        rd_resp;
  logic [`GAT_DBG_AXIL_DATA_W-1:0]   rdata_q;
  logic [`GAT_DBG_AXIL_DATA_W-1:0]   rd_data;
  logic [2*`GAT_DBG_NUM_STAGES-1:0]  flags;
  logic                              wr_fire;
  logic                              rd_fire;
  dbg_ctrl_t                         ctrl_q;

  // address and data are taken together, strobes are not looked at.
  assign wr_fire = (w_state == IDLE) && s_axil_awvalid_i && s_axil_wvalid_i;
  assign rd_fire = (r_state == IDLE) && s_axil_arvalid_i;

  assign s_axil_awready_o = wr_fire;
  assign s_axil_wready_o  = wr_fire;
  assign s_axil_bvalid_o  = (w_state == RESP);
  assign s_axil_bresp_o   = bresp_q;
  assign s_axil_arready_o = (r_state == IDLE);
  assign s_axil_rvalid_o  = (r_state == RESP);
  assign s_axil_rdata_o   = rdata_q;
  assign s_axil_rresp_o   = rresp_q;
  assign ctrl_o           = ctrl_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_state            <= IDLE;
      bresp_q            <= OKAY;
      ctrl_q.clear       <= 1'b0;
      ctrl_q.trig_addr_a <= `GAT_DBG_TRIG_A_RST;
      ctrl_q.trig_addr_b <= `GAT_DBG_TRIG_B_RST;
      ctrl_q.lane_sel    <= `GAT_DBG_LANE_SEL_RST;
      ctrl_q.feat_limit  <= `GAT_DBG_FEAT_LIM_RST;
    end else begin
      // clear is a single cycle pulse.
      ctrl_q.clear <= 1'b0;
      case (w_state)
        IDLE: begin
          if (wr_fire) begin
            w_state <= RESP;
            bresp_q <= OKAY;
            case (s_axil_awaddr_i)
              `GAT_DBG_REG_CTRL:     ctrl_q.clear <= s_axil_wdata_i[0];
              `GAT_DBG_REG_TRIG_A:   ctrl_q.trig_addr_a <= s_axil_wdata_i[`GAT_DBG_WH_ADDR_W-1:0];
              `GAT_DBG_REG_TRIG_B:   ctrl_q.trig_addr_b <= s_axil_wdata_i[`GAT_DBG_WH_ADDR_W-1:0];
              `GAT_DBG_REG_LANE:     ctrl_q.lane_sel <= s_axil_wdata_i[`GAT_DBG_LANE_SEL_W-1:0];
              `GAT_DBG_REG_FEAT_LIM: ctrl_q.feat_limit <= s_axil_wdata_i[`GAT_DBG_FEAT_ADDR_W-1:0];
              // read-only offsets take the write silently.
              `GAT_DBG_REG_ID, `GAT_DBG_REG_CFG, `GAT_DBG_REG_FLAGS,
              `GAT_DBG_REG_CNT0, `GAT_DBG_REG_CNT1, `GAT_DBG_REG_CNT2, `GAT_DBG_REG_CNT3,
              `GAT_DBG_REG_CAP_A, `GAT_DBG_REG_CAP_B,
              `GAT_DBG_REG_FEAT_STAT, `GAT_DBG_REG_FEAT_DIN: bresp_q <= OKAY;
              default:               bresp_q <= SLVERR;
            endcase
          end
        end
        RESP: begin
          if (s_axil_bready_i) begin
            w_state <= IDLE;
          end
        end
        default: w_state <= IDLE;
      endcase
    end
  end

  // spmm sits in the top pair, aggr in the bottom pair.
  always_comb begin
    for (int s = 0; s < `GAT_DBG_NUM_STAGES; s++) begin
      flags[2*(`GAT_DBG_NUM_STAGES-1-s)+1] = stage_status_i[s].vld_seen;
      flags[2*(`GAT_DBG_NUM_STAGES-1-s)]   = stage_status_i[s].rdy_seen;
    end
  end

  always_comb begin
    rd_data = '0;
    rd_resp = OKAY;
    case (s_axil_araddr_i)
      `GAT_DBG_REG_ID:        rd_data = `GAT_DBG_ID;
      `GAT_DBG_REG_CFG:       rd_data = `GAT_DBG_H_NUM_SPARSE;
      `GAT_DBG_REG_FLAGS:     rd_data[2*`GAT_DBG_NUM_STAGES-1:0] = flags;
      `GAT_DBG_REG_CNT0:      rd_data = stage_status_i[SPMM].count;
      `GAT_DBG_REG_CNT1:      rd_data = stage_status_i[DMVM].count;
      `GAT_DBG_REG_CNT2:      rd_data = stage_status_i[SM].count;
      `GAT_DBG_REG_CNT3:      rd_data = stage_status_i[AGGR].count;
      `GAT_DBG_REG_CTRL:      rd_data = '0;
      `GAT_DBG_REG_TRIG_A:    rd_data[`GAT_DBG_WH_ADDR_W-1:0] = ctrl_q.trig_addr_a;
      `GAT_DBG_REG_TRIG_B:    rd_data[`GAT_DBG_WH_ADDR_W-1:0] = ctrl_q.trig_addr_b;
      `GAT_DBG_REG_LANE:      rd_data[`GAT_DBG_LANE_SEL_W-1:0] = ctrl_q.lane_sel;
      `GAT_DBG_REG_CAP_A: begin
        rd_data[`GAT_DBG_LANE_W-1:0] = cap_status_i.cap_a;
        rd_data[31]                  = cap_status_i.hit_a;
      end
      `GAT_DBG_REG_CAP_B: begin
        rd_data[`GAT_DBG_LANE_W-1:0] = cap_status_i.cap_b;
        rd_data[31]                  = cap_status_i.hit_b;
      end
      `GAT_DBG_REG_FEAT_LIM:  rd_data[`GAT_DBG_FEAT_ADDR_W-1:0] = ctrl_q.feat_limit;
      `GAT_DBG_REG_FEAT_STAT: begin
        rd_data[`GAT_DBG_FEAT_ADDR_W-1:0] = feat_status_i.first_addr;
        rd_data[31]                       = feat_status_i.hit;
      end
      `GAT_DBG_REG_FEAT_DIN:  rd_data = feat_status_i.first_din;
      default:                rd_resp = SLVERR;
    endcase
  end

  // status is sampled in the address cycle and held until rready.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_state <= IDLE;
      rresp_q <= OKAY;
      rdata_q <= '0;
    end else begin
      case (r_state)
        IDLE: begin
          if (rd_fire) begin
            r_state <= RESP;
            rresp_q <= rd_resp;
            rdata_q <= rd_data;
          end
        end
        RESP: begin
          if (s_axil_rready_i) begin
            r_state <= IDLE;
          end
        end
        default: r_state <= IDLE;
      endcase
    end
  end

endmodule

/* hdl/feat_write_watch.sv */
`timescale 1ns/10ps
`include "gat_debug_config.svh"

module feat_write_watch (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            ena_i,
  input  logic [`GAT_DBG_FEAT_ADDR_W-1:0] addr_i,
  input  logic [`GAT_DBG_FEAT_DATA_W-1:0] din_i,
  input  gat_debug_pkg::dbg_ctrl_t        ctrl_i,
  output gat_debug_pkg::feat_status_t     status_o
);

  logic bad_write;

  assign bad_write = ena_i && (addr_i >= ctrl_i.feat_limit);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_o <= '0;
    end else if (ctrl_i.clear) begin
      status_o <= '0;
    end else if (bad_write && !status_o.hit) begin
      // only the first offender is kept.
      status_o.hit        <= 1'b1;
      status_o.first_addr <= addr_i;
      status_o.first_din  <= din_i;
    end
  end

endmodule

/* hdl/sppe_capture.sv */
`timescale 1ns/10ps
`include "gat_debug_config.svh"

module sppe_capture (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic [`GAT_DBG_NUM_LANES-1:0][`GAT_DBG_LANE_W-1:0] sppe_i,
  input  logic [`GAT_DBG_WH_ADDR_W-1:0]                      wh_addr_i,
  input  logic                                               spmm_rdy_i,
  input  gat_debug_pkg::dbg_ctrl_t                           ctrl_i,
  output gat_debug_pkg::cap_status_t                         status_o
);

  logic [`GAT_DBG_LANE_W-1:0] lane;
  logic                       match_a;
  logic                       match_b;

  assign lane    = sppe_i[ctrl_i.lane_sel];
  assign match_a = spmm_rdy_i && (wh_addr_i == ctrl_i.trig_addr_a);
  assign match_b = spmm_rdy_i && (wh_addr_i == ctrl_i.trig_addr_b);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_o <= '0;
    end else if (ctrl_i.clear) begin
      status_o <= '0;
    end else begin
      // latest match wins.
      if (match_a) begin
        status_o.cap_a <= lane;
        status_o.hit_a <= 1'b1;
      end
      if (match_b) begin
        status_o.cap_b <= lane;
        status_o.hit_b <= 1'b1;
      end
    end
  end

endmodule

/* hdl/stage_monitor.sv */
`timescale 1ns/10ps

module stage_monitor (
  input  logic                         clk,
  input  logic                         rst_n,
  input  gat_debug_pkg::hs_probe_t     probe_i,
  input  logic                         clear_i,
  output gat_debug_pkg::stage_status_t status_o
);

  logic xfer;

  // one transfer per cycle with both sides high.
  assign xfer = probe_i.vld && probe_i.rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_o.vld_seen <= 1'b0;
      status_o.rdy_seen <= 1'b0;
      status_o.count    <= '0;
    end else if (clear_i) begin
      // an event in the clear cycle is dropped.
      status_o.vld_seen <= 1'b0;
      status_o.rdy_seen <= 1'b0;
      status_o.count    <= '0;
    end else begin
      if (probe_i.vld) begin
        status_o.vld_seen <= 1'b1;
      end
      if (probe_i.rdy) begin
        status_o.rdy_seen <= 1'b1;
      end
      if (xfer) begin
        status_o.count <= status_o.count + 1'b1;
      end
    end
  end

endmodule

/* hdl/gat_debug_pkg.sv */
`include "gat_debug_config.svh"

package gat_debug_pkg;

  typedef enum logic [1:0] {
    SPMM = 2'd0,
    DMVM = 2'd1,
    SM   = 2'd2,
    AGGR = 2'd3
  } stage_e;

  typedef enum logic {
    IDLE = 1'b0,
    RESP = 1'b1
  } axil_state_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  typedef struct packed {
    logic vld;
    logic rdy;
  } hs_probe_t;

  typedef struct packed {
    hs_probe_t [`GAT_DBG_NUM_STAGES-1:0]                hs;
    logic [`GAT_DBG_NUM_LANES-1:0][`GAT_DBG_LANE_W-1:0] sppe;
    logic [`GAT_DBG_WH_ADDR_W-1:0]                      wh_addr;
    logic                                               feat_ena;
    logic [`GAT_DBG_FEAT_ADDR_W-1:0]                    feat_addr;
    logic [`GAT_DBG_FEAT_DATA_W-1:0]                    feat_din;
  } gat_probe_t;

  typedef struct packed {
    logic                            clear;
    logic [`GAT_DBG_WH_ADDR_W-1:0]   trig_addr_a;
    logic [`GAT_DBG_WH_ADDR_W-1:0]   trig_addr_b;
    logic [`GAT_DBG_LANE_SEL_W-1:0]  lane_sel;
    logic [`GAT_DBG_FEAT_ADDR_W-1:0] feat_limit;
  } dbg_ctrl_t;

  typedef struct packed {
    logic                      vld_seen;
    logic                      rdy_seen;
    logic [`GAT_DBG_CNT_W-1:0] count;
  } stage_status_t;

  typedef struct packed {
    logic [`GAT_DBG_LANE_W-1:0] cap_a;
    logic [`GAT_DBG_LANE_W-1:0] cap_b;
    logic                       hit_a;
    logic                       hit_b;
  } cap_status_t;

  typedef struct packed {
    logic                            hit;
    logic [`GAT_DBG_FEAT_ADDR_W-1:0] first_addr;
    logic [`GAT_DBG_FEAT_DATA_W-1:0] first_din;
  } feat_status_t;

endpackage

/* hdl/gat_debug_config.svh */
`ifndef GAT_DEBUG_CONFIG_SVH
`define GAT_DEBUG_CONFIG_SVH

// observed accelerator sizes.
`define GAT_DBG_NUM_STAGES    4
`define GAT_DBG_NUM_LANES     16
`define GAT_DBG_LANE_W        12
`define GAT_DBG_LANE_SEL_W    4
`define GAT_DBG_WH_ADDR_W     14
`define GAT_DBG_FEAT_ADDR_W   16
`define GAT_DBG_FEAT_DATA_W   32
`define GAT_DBG_CNT_W         32
`define GAT_DBG_AXIL_ADDR_W   8
`define GAT_DBG_AXIL_DATA_W   32

// identification and reset values.
`define GAT_DBG_ID            32'h4741_5444
`define GAT_DBG_H_NUM_SPARSE  32'd12
`define GAT_DBG_TRIG_A_RST    14'd10
`define GAT_DBG_TRIG_B_RST    14'd20
`define GAT_DBG_LANE_SEL_RST  4'd2
`define GAT_DBG_FEAT_LIM_RST  16'd43328

// register offsets.
`define GAT_DBG_REG_ID        8'h00
`define GAT_DBG_REG_CFG       8'h04
`define GAT_DBG_REG_FLAGS     8'h08
`define GAT_DBG_REG_CNT0      8'h0C
`define GAT_DBG_REG_CNT1      8'h10
`define GAT_DBG_REG_CNT2      8'h14
`define GAT_DBG_REG_CNT3      8'h18
`define GAT_DBG_REG_CTRL      8'h1C
`define GAT_DBG_REG_TRIG_A    8'h20
`define GAT_DBG_REG_TRIG_B    8'h24
`define GAT_DBG_REG_LANE      8'h28
`define GAT_DBG_REG_CAP_A     8'h2C
`define GAT_DBG_REG_CAP_B     8'h30
`define GAT_DBG_REG_FEAT_LIM  8'h34
`define GAT_DBG_REG_FEAT_STAT 8'h38
`define GAT_DBG_REG_FEAT_DIN  8'h3C

`endif
